// ==== pipeCore.f ====
+incdir+hw
hw/pipeCorePkg.sv
hw/instrDecoder.sv
hw/regFile.sv
hw/hazardUnit.sv
hw/executeStage.sv
hw/pipeCore.sv
test/pipeCoreTb.sv

// ==== Makefile ====
TOP := pipeCoreTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f pipeCore.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Test passed$$" sim.log

lint:
	verilator --lint-only -Wall --timing -f pipeCore.f --top-module pipeCore

clean:
	rm -rf obj_dir sim.log

// ==== test/pipeCoreTestdata.txt ====
// all values hex; @00 header: cycle budget, program words, data pairs, expected stores
// @10 program words from byte 0; @60 data (address value); @80 stores (address data)
@00
00000050 00000023 00000002 0000000d
@10
// dependent chain: lui, ori, addi, add, sub, and, or, slt, slt
3C011234 34215678 2002FFF0 00221820
00612022 00222824 00833025 0081382A
0024402A
// store the chain, data forwarded into each sw
AC080114 AC070110 AC06010C AC050108
AC040104 AC030100 AC010118
// load then dependent add and sw, then load feeding sw directly
8C090180 01295020 AC0A011C 8C0B0184
AC0B0120
// addi r12, taken beq over two wrong-path stores, landing store
200C0001 11870002 AC0C01F0 AC0C01F4
AC0C0124
// taken bne over one wrong-path store, landing store
14E80001 AC0701F8 AC020128
// not-taken beq, following store must appear
10E80001 AC06012C
// j over one store, target store, then spin on j
08000021 AC0101FC AC0A0130 08000022
@60
00000180 00000123
00000184 89ABCDEF
@80
// expected stores in order
00000114 00000000
00000110 00000001
0000010C FFFFFFF8
00000108 12345670
00000104 FFFFFFF0
00000100 12345668
00000118 12345678
0000011C 00000246
00000120 89ABCDEF
00000124 00000001
00000128 FFFFFFF0
0000012C FFFFFFF8
00000130 00000246

// ==== test/pipeCoreTb.sv ====
// testbench for pipeCore, acts as both memories and checks every store against the testdata file
`timescale 1ns/1ps
`include "pipeCore_config.svh"

module pipeCoreTb import pipeCorePkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 3;
    localparam int PROG_WORDS = 64;
    localparam int DATA_WORDS = 256;
    // word offsets of the sections in the testdata file
    localparam int PROG_BASE = 'h10;
    localparam int DATA_BASE = 'h60;
    localparam int STORE_BASE = 'h80;

    logic clk;
    logic reset;
    word_t instrAddr;
    word_t instr;
    word_t memAddr;
    word_t memWrData;
    logic memWrite;
    logic memRead;
    word_t memRdData;

    logic [31:0] testData [0:255];
    word_t progMem [0:PROG_WORDS-1];
    word_t dataMem [0:DATA_WORDS-1];
    word_t expAddr [$];
    word_t expData [$];
    int budgetCycles;
    int storeCount;
    int cycleCount;
    int resetErrors;
    int storeErrors;
    int extraStores;
    int lateErrors;

    pipeCore i_dut (
        .clk      (clk),
        .reset    (reset),
        .instrAddr(instrAddr),
        .instr    (instr),
        .memAddr  (memAddr),
        .memWrData(memWrData),
        .memWrite (memWrite),
        .memRead  (memRead),
        .memRdData(memRdData)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic checkWord(input string name, input word_t expected, input word_t actual,
                             inout int errors);
        if (actual !== expected) begin
            errors++;
            $display("Error %s: expected %h, actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual,
                            inout int errors);
        if (actual !== expected) begin
            errors++;
            $display("Error %s: expected %b, actual %b at %0t", name, expected, actual, $time);
        end
    endtask

    // header words, then program, initial data pairs and expected store pairs
    task automatic loadTestData();
        int progCount;
        int dataCount;
        int expCount;
        word_t addr;
        $readmemh("test/pipeCoreTestdata.txt", testData);
        budgetCycles = int'(testData[0]);
        progCount = int'(testData[1]);
        dataCount = int'(testData[2]);
        expCount = int'(testData[3]);
        for (int i = 0; i < PROG_WORDS; i++) begin
            progMem[i] = (i < progCount) ? testData[PROG_BASE + i] : '0;
        end
        // background data is noise, the program never reads it
        for (int i = 0; i < DATA_WORDS; i++) begin
            dataMem[i] = $urandom();
        end
        for (int i = 0; i < dataCount; i++) begin
            addr = testData[DATA_BASE + 2 * i];
            dataMem[addr[9:2]] = testData[DATA_BASE + 2 * i + 1];
        end
        for (int i = 0; i < expCount; i++) begin
            expAddr.push_back(testData[STORE_BASE + 2 * i]);
            expData.push_back(testData[STORE_BASE + 2 * i + 1]);
        end
    endtask

    // one store strobe, compared in order against the expected list
    task automatic handleStore();
        if (storeCount >= expAddr.size()) begin
            extraStores++;
            $display("unexpected store of %h to address %h after the expected sequence at %0t",
                     memWrData, memAddr, $time);
        end else begin
            checkWord($sformatf("store %0d address", storeCount), expAddr[storeCount], memAddr,
                      storeErrors);
            checkWord($sformatf("store %0d data", storeCount), expData[storeCount], memWrData,
                      storeErrors);
        end
        checkBit($sformatf("store %0d memRead", storeCount), 1'b0, memRead, storeErrors);
        dataMem[memAddr[9:2]] = memWrData;
        storeCount++;
    endtask

    task automatic checkReset(input string phase);
        checkBit({phase, " memWrite"}, 1'b0, memWrite, resetErrors);
        checkBit({phase, " memRead"}, 1'b0, memRead, resetErrors);
        checkWord({phase, " instrAddr"}, `RESET_PC, instrAddr, resetErrors);
    endtask

    // memory model, mid-cycle when pc and memory-stage outputs are settled
    initial begin
        instr = '0;
        memRdData = '0;
        storeCount = 0;
        storeErrors = 0;
        extraStores = 0;
        void'($urandom(32'h988b_1a11));
        loadTestData();
        forever begin
            @(negedge clk);
            if (reset && memWrite) begin
                handleStore();
            end
            // outside the program reads as zero, a no-op
            if (instrAddr < word_t'(PROG_WORDS * 4)) begin
                instr = progMem[instrAddr[7:2]];
            end else begin
                instr = '0;
            end
            memRdData = dataMem[memAddr[9:2]];
        end
    end

    initial begin
        reset = 1'b0;
        cycleCount = 0;
        resetErrors = 0;
        lateErrors = 0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            checkReset("in reset");
        end
        reset = 1'b1;
        // still before the first active edge
        #1;
        checkReset("after reset");
        while (storeCount < expAddr.size()) begin
            @(posedge clk);
            cycleCount++;
        end
        if (cycleCount > budgetCycles) begin
            lateErrors++;
            $display("stores finished after %0d cycles, over the budget of %0d",
                     cycleCount, budgetCycles);
        end
        // keep running so stray strobes get caught
        while (cycleCount < budgetCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("errors: reset %0d, store values %0d, extra stores %0d, late %0d",
                 resetErrors, storeErrors, extraStores, lateErrors);
        if ((resetErrors + storeErrors + extraStores + lateErrors) == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog, budget plus reset plus some slack
    initial begin
        #1;
        #((budgetCycles + RESET_CYCLES + 20) * CLK_PERIOD);
        $display("timeout: only %0d of %0d stores seen, errors: reset %0d, store values %0d",
                 storeCount, expAddr.size(), resetErrors, storeErrors);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== hw/pipeCore.sv ====
// five-stage integer core top, PC and pipeline registers with both memories outside
`timescale 1ns/1ps
`include "pipeCore_config.svh"

module pipeCore import pipeCorePkg::*; (
    input  logic  clk,
    input  logic  reset,
    output word_t instrAddr,
    input  word_t instr,
    output word_t memAddr,
    output word_t memWrData,
    output logic  memWrite,
    output logic  memRead,
    input  word_t memRdData
);

    word_t pc;
    word_t pcPlus4;
    word_t nextPc;
    word_t jumpTarget;
    word_t branchTarget;

    instrWord_t ifIdInstr;
    word_t ifIdPcPlus4;

    exCtrl_t decExCtrl;
    memCtrl_t decMemCtrl;
    wbCtrl_t decWbCtrl;
    word_t decImm;
    logic isJump;
    logic jumpTaken;
    word_t rdDataA;
    word_t rdDataB;

    idExReg_t idExNext;
    idExReg_t idEx;
    exMemReg_t exMemNext;
    exMemReg_t exMem;
    memWbReg_t memWbNext;
    memWbReg_t memWb;

    fwdSel_t fwdA;
    fwdSel_t fwdB;
    logic stall;
    logic flushDecode;
    logic branchTaken;

    // fetch
    assign instrAddr = pc;
    assign pcPlus4 = pc + 4;

    // a stalled jump waits in decode, a taken branch overrides it
    assign jumpTaken = isJump && !stall && !flushDecode;
    assign jumpTarget = {ifIdPcPlus4[31:28], ifIdInstr.jFields.target26, 2'b00};

    always_comb begin
        if (branchTaken) begin
            nextPc = branchTarget;
        end else if (stall) begin
            nextPc = pc;
        end else if (jumpTaken) begin
            nextPc = jumpTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc <= `RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

    // IF/ID, an all-zero word decodes as a no-op
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ifIdInstr <= '0;
            ifIdPcPlus4 <= '0;
        end else if (flushDecode || jumpTaken) begin
            ifIdInstr <= '0;
            ifIdPcPlus4 <= '0;
        end else if (!stall) begin
            ifIdInstr <= instr;
            ifIdPcPlus4 <= pcPlus4;
        end
    end

    // decode
    instrDecoder i_decoder (
        .instr  (ifIdInstr),
        .exCtrl (decExCtrl),
        .memCtrl(decMemCtrl),
        .wbCtrl (decWbCtrl),
        .imm    (decImm),
        .isJump (isJump)
    );

    // writeback port drives the same-cycle bypass
    regFile i_regFile (
        .clk    (clk),
        .reset  (reset),
        .rdAddrA(ifIdInstr.rFields.rs),
        .rdAddrB(ifIdInstr.rFields.rt),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB),
        .wrEn   (memWb.wbCtrl.regWrite),
        .wrAddr (memWb.destReg),
        .wrData (memWb.wbData)
    );

    hazardUnit i_hazard (
        .clk        (clk),
        .reset      (reset),
        .idRs       (ifIdInstr.rFields.rs),
        .idRt       (ifIdInstr.rFields.rt),
        .idEx       (idEx),
        .exMem      (exMem),
        .memWb      (memWb),
        .branchTaken(branchTaken),
        .fwdA       (fwdA),
        .fwdB       (fwdB),
        .stall      (stall),
        .flushDecode(flushDecode)
    );

    always_comb begin
        idExNext.exCtrl = decExCtrl;
        idExNext.memCtrl = decMemCtrl;
        idExNext.wbCtrl = decWbCtrl;
        idExNext.pcPlus4 = ifIdPcPlus4;
        idExNext.rdDataA = rdDataA;
        idExNext.rdDataB = rdDataB;
        idExNext.imm = decImm;
        idExNext.rs = ifIdInstr.rFields.rs;
        idExNext.rt = ifIdInstr.rFields.rt;
        idExNext.rd = ifIdInstr.rFields.rd;
    end

    // bubble on stall or flush
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            idEx <= '0;
        end else if (flushDecode || stall) begin
            idEx <= '0;
        end else begin
            idEx <= idExNext;
        end
    end

    // execute
    executeStage i_execute (
        .idEx        (idEx),
        .fwdA        (fwdA),
        .fwdB        (fwdB),
        .memFwd      (exMem.aluResult),
        .wbFwd       (memWb.wbData),
        .exMem       (exMemNext),
        .branchTaken (branchTaken),
        .branchTarget(branchTarget)
    );

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            exMem <= '0;
        end else begin
            exMem <= exMemNext;
        end
    end

    // memory stage strobes straight from EX/MEM
    assign memAddr = exMem.aluResult;
    assign memWrData = exMem.storeData;
    assign memWrite = exMem.memCtrl.memWrite;
    assign memRead = exMem.memCtrl.memRead;

    // load data or ALU result toward writeback
    assign memWbNext.wbCtrl = exMem.wbCtrl;
    assign memWbNext.wbData = exMem.wbCtrl.memToReg ? memRdData : exMem.aluResult;
    assign memWbNext.destReg = exMem.destReg;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            memWb <= '0;
        end else begin
            memWb <= memWbNext;
        end
    end

    // one memory op per instruction in the memory stage
    assert property (@(posedge clk) disable iff (!reset) !(memWrite && memRead));

endmodule

// ==== hw/executeStage.sv ====
// execute stage, forwarding muxes, ALU and branch resolution feeding the EX/MEM register
`timescale 1ns/1ps

module executeStage import pipeCorePkg::*; (
    input  idExReg_t  idEx,
    input  fwdSel_t   fwdA,
    input  fwdSel_t   fwdB,
    input  word_t     memFwd,
    input  word_t     wbFwd,
    output exMemReg_t exMem,
    output logic      branchTaken,
    output word_t     branchTarget
);

    word_t srcA;
    word_t srcB;
    word_t aluB;
    word_t aluResult;

    function automatic word_t pickOperand(fwdSel_t sel, word_t regVal, word_t memVal,
                                          word_t wbVal);
        case (sel)
            FWD_MEM: return memVal;
            FWD_WB:  return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign srcA = pickOperand(fwdA, idEx.rdDataA, memFwd, wbFwd);
    assign srcB = pickOperand(fwdB, idEx.rdDataB, memFwd, wbFwd);

    // immediate replaces rt for I-type and memory ops
    assign aluB = idEx.exCtrl.useImm ? idEx.imm : srcB;

    always_comb begin
        case (idEx.exCtrl.aluOp)
            ALU_ADD: aluResult = srcA + aluB;
            ALU_SUB: aluResult = srcA - aluB;
            ALU_AND: aluResult = srcA & aluB;
            ALU_OR:  aluResult = srcA | aluB;
            ALU_SLT: aluResult = word_t'($signed(srcA) < $signed(aluB));
            // lui, low half of the immediate moved up
            ALU_LUI: aluResult = {aluB[15:0], 16'h0000};
            default: aluResult = '0;
        endcase
    end

    // beq on equal, bne on not equal
    assign branchTaken = idEx.exCtrl.isBranch &&
                         ((srcA == srcB) != idEx.exCtrl.branchOnNe);
    assign branchTarget = idEx.pcPlus4 + {idEx.imm[29:0], 2'b00};

    assign exMem.memCtrl = idEx.memCtrl;
    assign exMem.wbCtrl = idEx.wbCtrl;
    assign exMem.aluResult = aluResult;
    // store data takes the forwarded rt, not the immediate
    assign exMem.storeData = srcB;
    assign exMem.destReg = idEx.exCtrl.regDstRd ? idEx.rd : idEx.rt;

endmodule

// ==== hw/hazardUnit.sv ====
// pipeline hazard control, forwarding selects for execute plus load-use stall and branch flush
`timescale 1ns/1ps

module hazardUnit import pipeCorePkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  regAddr_t  idRs,
    input  regAddr_t  idRt,
    input  idExReg_t  idEx,
    input  exMemReg_t exMem,
    input  memWbReg_t memWb,
    input  logic      branchTaken,
    output fwdSel_t   fwdA,
    output fwdSel_t   fwdB,
    output logic      stall,
    output logic      flushDecode
);

    // newest producer wins, r0 never forwards
    function automatic fwdSel_t pickSource(regAddr_t src, exMemReg_t exMemIn,
                                           memWbReg_t memWbIn);
        fwdSel_t sel;
        sel = FWD_NONE;
        if (memWbIn.wbCtrl.regWrite && (memWbIn.destReg != '0) && (memWbIn.destReg == src)) begin
            sel = FWD_WB;
        end
        if (exMemIn.wbCtrl.regWrite && (exMemIn.destReg != '0) && (exMemIn.destReg == src)) begin
            sel = FWD_MEM;
        end
        return sel;
    endfunction

    assign fwdA = pickSource(idEx.rs, exMem, memWb);
    assign fwdB = pickSource(idEx.rt, exMem, memWb);

    // load in execute feeding decode, hold one cycle
    // loads always write rt
    assign stall = idEx.memCtrl.memRead && (idEx.rt != '0) &&
                   ((idEx.rt == idRs) || (idEx.rt == idRt));

    // taken branch squashes both younger stages
    assign flushDecode = branchTaken;

    // a load sitting in execute is never the taken branch
    assert property (@(posedge clk) disable iff (!reset) !(stall && flushDecode));

endmodule

// ==== hw/regFile.sv ====
// architectural registers, two read ports for decode and one write port from writeback
`timescale 1ns/1ps
`include "pipeCore_config.svh"

module regFile import pipeCorePkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  regAddr_t rdAddrA,
    input  regAddr_t rdAddrB,
    output word_t    rdDataA,
    output word_t    rdDataB,
    input  logic     wrEn,
    input  regAddr_t wrAddr,
    input  word_t    wrData
);

    word_t regs [`REG_COUNT];
    logic bypassA;
    logic bypassB;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // write-through so decode sees the value retiring this cycle, never for r0
    assign bypassA = wrEn && (wrAddr != '0) && (wrAddr == rdAddrA);
    assign bypassB = wrEn && (wrAddr != '0) && (wrAddr == rdAddrB);
    assign rdDataA = bypassA ? wrData : regs[rdAddrA];
    assign rdDataB = bypassB ? wrData : regs[rdAddrB];

    // r0 stays zero even when writeback targets it
    assert property (@(posedge clk) disable iff (!reset)
        ((rdAddrA == '0) |-> (rdDataA == '0)) and ((rdAddrB == '0) |-> (rdDataB == '0)));

endmodule

// ==== hw/instrDecoder.sv ====
// decode stage control, turns one instruction word into per-stage control and an immediate
`timescale 1ns/1ps

module instrDecoder import pipeCorePkg::*; (
    input  instrWord_t instr,
    output exCtrl_t    exCtrl,
    output memCtrl_t   memCtrl,
    output wbCtrl_t    wbCtrl,
    output word_t      imm,
    output logic       isJump
);

    always_comb begin
        // everything off by default, so unknown words act as a no-op
        exCtrl = '0;
        memCtrl = '0;
        wbCtrl = '0;
        case (instr.rFields.opcode)
            OP_RTYPE: begin
                exCtrl.regDstRd = 1'b1;
                wbCtrl.regWrite = 1'b1;
                case (instr.rFields.funct)
                    FN_ADD: exCtrl.aluOp = ALU_ADD;
                    FN_SUB: exCtrl.aluOp = ALU_SUB;
                    FN_AND: exCtrl.aluOp = ALU_AND;
                    FN_OR:  exCtrl.aluOp = ALU_OR;
                    FN_SLT: exCtrl.aluOp = ALU_SLT;
                    default: begin
                        // shifts and the rest, dropped back to a no-op
                        exCtrl = '0;
                        wbCtrl = '0;
                    end
                endcase
            end
            OP_ADDI: begin
                exCtrl.aluOp = ALU_ADD;
                exCtrl.useImm = 1'b1;
                wbCtrl.regWrite = 1'b1;
            end
            OP_ORI: begin
                exCtrl.aluOp = ALU_OR;
                exCtrl.useImm = 1'b1;
                wbCtrl.regWrite = 1'b1;
            end
            OP_LUI: begin
                exCtrl.aluOp = ALU_LUI;
                exCtrl.useImm = 1'b1;
                wbCtrl.regWrite = 1'b1;
            end
            OP_LW: begin
                // address is rs plus offset
                exCtrl.aluOp = ALU_ADD;
                exCtrl.useImm = 1'b1;
                memCtrl.memRead = 1'b1;
                wbCtrl.regWrite = 1'b1;
                wbCtrl.memToReg = 1'b1;
            end
            OP_SW: begin
                exCtrl.aluOp = ALU_ADD;
                exCtrl.useImm = 1'b1;
                memCtrl.memWrite = 1'b1;
            end
            OP_BEQ: exCtrl.isBranch = 1'b1;
            OP_BNE: begin
                exCtrl.isBranch = 1'b1;
                exCtrl.branchOnNe = 1'b1;
            end
            // j needs no downstream control, it is handled in decode
            default: exCtrl = '0;
        endcase
    end

    // ori zero-extends, everything else sign-extends
    assign imm = (instr.iFields.opcode == OP_ORI) ?
                 {16'h0000, instr.iFields.imm16} :
                 {{16{instr.iFields.imm16[15]}}, instr.iFields.imm16};

    assign isJump = (instr.jFields.opcode == OP_J);

endmodule

// ==== hw/pipeCorePkg.sv ====
// shared types for the pipelined core; RTL modules pull them in by wildcard import
`include "pipeCore_config.svh"

package pipeCorePkg;

    typedef logic [`WORD_WIDTH-1:0] word_t;
    typedef logic [4:0] regAddr_t;

    // kept primary opcodes
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    // kept R-type function codes
    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_t;

    // one instruction word, three field layouts
    typedef union packed {
        struct packed {
            opcode_t opcode;
            regAddr_t rs;
            regAddr_t rt;
            regAddr_t rd;
            logic [4:0] shamt;
            funct_t funct;
        } rFields;
        struct packed {
            opcode_t opcode;
            regAddr_t rs;
            regAddr_t rt;
            logic [15:0] imm16;
        } iFields;
        struct packed {
            opcode_t opcode;
            logic [25:0] target26;
        } jFields;
    } instrWord_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } aluOp_t;

    // operand source for execute, picked by the hazard unit
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_WB   = 2'b01,
        FWD_MEM  = 2'b10
    } fwdSel_t;

    typedef struct packed {
        aluOp_t aluOp;
        logic useImm;
        logic regDstRd;
        logic isBranch;
        logic branchOnNe;
    } exCtrl_t;

    typedef struct packed {
        logic memRead;
        logic memWrite;
    } memCtrl_t;

    typedef struct packed {
        logic regWrite;
        logic memToReg;
    } wbCtrl_t;

    typedef struct packed {
        exCtrl_t exCtrl;
        memCtrl_t memCtrl;
        wbCtrl_t wbCtrl;
        word_t pcPlus4;
        word_t rdDataA;
        word_t rdDataB;
        word_t imm;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t rd;
    } idExReg_t;

    typedef struct packed {
        memCtrl_t memCtrl;
        wbCtrl_t wbCtrl;
        word_t aluResult;
        word_t storeData;
        regAddr_t destReg;
    } exMemReg_t;

    typedef struct packed {
        wbCtrl_t wbCtrl;
        word_t wbData;
        regAddr_t destReg;
    } memWbReg_t;

endpackage

// ==== hw/pipeCore_config.svh ====
// core-wide sizing and reset constants, pulled in with `include by the package and RTL files
`ifndef PIPECORE_CONFIG_SVH
`define PIPECORE_CONFIG_SVH

// data and address width of the core
`define WORD_WIDTH 32

// architectural register count, index 0 is hardwired zero
`define REG_COUNT 32

// first fetch address once reset is released
`define RESET_PC 32'h0000_0000

`endif
